//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_measure_core
FILELIST  ?= measure_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
GOLDEN    ?= verif/measure_golden.txt
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(GOLDEN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/arp_reply_tx.sv
`timescale 1ns/1ps
`default_nettype none

module arp_reply_tx (
  input  wire                gmii_tx_clk,
  input  wire                sys_rst,
  arp_req_if.receiver        req,
  output measure_pkg::byte_t gmii_txd,
  output logic               gmii_tx_en
);

  measure_pkg::mac_addr_t    dst_mac;
  measure_pkg::ipv4_addr_t   dst_ip;
  measure_pkg::tx_count_t    cnt;          // Byte or gap cycle index
  logic                      sending;
  logic                      in_gap;
  logic                      last_gap;
  measure_pkg::byte_t [41:0] hdr;          // Ethernet and ARP header, 42 bytes
  logic [5:0]                hdr_idx;
  logic [1:0]                fcs_sel;
  logic [3:0][7:0]           fcs;
  logic                      crc_init;
  logic                      crc_en;

  assign hdr = {dst_mac, measure_pkg::LOCAL_MAC, measure_pkg::ETH_TYPE_ARP,
                measure_pkg::ARP_HTYPE_ETH, measure_pkg::ARP_PTYPE_IPV4, 8'h06, 8'h04,
                measure_pkg::ARP_OP_REPLY, measure_pkg::LOCAL_MAC, measure_pkg::LOCAL_IPV4,
                dst_mac, dst_ip};

  assign hdr_idx  = 6'(measure_pkg::TX_OFS_PAD - 7'd1 - cnt);   // hdr[41] goes first
  assign fcs_sel  = 2'(cnt - measure_pkg::TX_OFS_FCS);
  assign crc_init = sending && (cnt == measure_pkg::TX_OFS_DST);
  assign crc_en   = sending && (cnt >= measure_pkg::TX_OFS_DST) &&
                    (cnt < measure_pkg::TX_OFS_FCS);
  assign last_gap = in_gap && (cnt == measure_pkg::TX_GAP - 7'd1);

  assign gmii_tx_en = sending;
  assign req.credit = last_gap;

  always_comb begin
    gmii_txd = 8'h00;
    if (sending) begin
      if (cnt < measure_pkg::TX_OFS_DST - 7'd1)
        gmii_txd = 8'h55;                  // Preamble
      else if (cnt == measure_pkg::TX_OFS_DST - 7'd1)
        gmii_txd = 8'hd5;                  // SFD
      else if (cnt < measure_pkg::TX_OFS_PAD)
        gmii_txd = hdr[hdr_idx];
      else if (cnt >= measure_pkg::TX_OFS_FCS)
        gmii_txd = fcs[2'd3 - fcs_sel];
    end
  end

  eth_crc32 u_eth_crc32 (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .init        (crc_init),
    .data        (gmii_txd),
    .data_en     (crc_en),
    .crc         (fcs)
  );

  always_ff @(posedge gmii_tx_clk) begin
    if (req.push) begin
      dst_mac <= req.dst_mac;
      dst_ip  <= req.dst_ip;
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      sending <= 1'b0;
      in_gap  <= 1'b0;
      cnt     <= '0;
    end else if (req.push) begin
      sending <= 1'b1;
      cnt     <= '0;
    end else if (sending) begin
      if (cnt == measure_pkg::REPLY_LEN - 7'd1) begin
        sending <= 1'b0;                   // Last FCS byte out
        in_gap  <= 1'b1;
        cnt     <= '0;
      end else begin
        cnt <= cnt + 7'd1;
      end
    end else if (in_gap) begin
      cnt <= cnt + 7'd1;
      if (last_gap)
        in_gap <= 1'b0;
    end
  end

  // Queue holds its single credit until the gap has run out
  no_push_while_busy: assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    req.push |-> !sending && !in_gap);

endmodule

`default_nettype wire

//--- hdl/arp_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// One ARP reply request, credit flows back from the receiver
interface arp_req_if;

  logic                    push;      // One-cycle request strobe
  measure_pkg::mac_addr_t  dst_mac;   // Requester MAC
  measure_pkg::ipv4_addr_t dst_ip;    // Requester IPv4
  logic                    credit;    // One-cycle credit return

  modport sender (
    output push,
    output dst_mac,
    output dst_ip,
    input  credit
  );

  modport receiver (
    input  push,
    input  dst_mac,
    input  dst_ip,
    output credit
  );

endinterface

`default_nettype wire

//--- hdl/arp_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module arp_req_queue (
  input wire          gmii_tx_clk,
  input wire          sys_rst,
  arp_req_if.receiver req_in,
  arp_req_if.sender   req_out
);

  measure_pkg::mac_addr_t  mac_mem [measure_pkg::REPLY_QUEUE_DEPTH];
  measure_pkg::ipv4_addr_t ip_mem  [measure_pkg::REPLY_QUEUE_DEPTH];
  measure_pkg::qptr_t      wr_ptr;
  measure_pkg::qptr_t      rd_ptr;
  measure_pkg::credit_t    count;        // Occupancy
  logic                    tx_credit;    // Transmitter can take one request
  logic                    forward;

  function automatic measure_pkg::qptr_t next_ptr(input measure_pkg::qptr_t p);
    return (p == measure_pkg::QPTR_LAST) ? '0 : p + 1'b1;
  endfunction

  assign forward = (count != '0) && tx_credit;

  always_ff @(posedge gmii_tx_clk) begin
    if (req_in.push) begin
      mac_mem[wr_ptr] <= req_in.dst_mac;
      ip_mem[wr_ptr]  <= req_in.dst_ip;
    end
    if (forward) begin
      req_out.dst_mac <= mac_mem[rd_ptr];   // Oldest entry
      req_out.dst_ip  <= ip_mem[rd_ptr];
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      tx_credit     <= 1'b1;
      req_out.push  <= 1'b0;
      req_in.credit <= 1'b0;
    end else begin
      req_out.push  <= forward;
      req_in.credit <= forward;             // Entry freed upstream
      if (req_in.push)
        wr_ptr <= next_ptr(wr_ptr);
      if (forward)
        rd_ptr <= next_ptr(rd_ptr);
      case ({req_in.push, forward})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (forward)
        tx_credit <= 1'b0;
      else if (req_out.credit)
        tx_credit <= 1'b1;
    end
  end

  // Upstream credit accounting keeps the parser from overrunning the FIFO
  no_push_when_full: assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    req_in.push |-> count != measure_pkg::QUEUE_CREDITS);

endmodule

`default_nettype wire

//--- hdl/eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
  input  wire                     gmii_tx_clk,
  input  wire                     sys_rst,
  input  wire                     init,
  input  wire measure_pkg::byte_t data,
  input  wire                     data_en,
  output logic [31:0]             crc
);

  logic [31:0] crc_reg;
  logic [31:0] crc_base;

  // One byte through the polynomial, bit 0 first as on the wire
  function automatic logic [31:0] crc_step(input logic [31:0] c,
                                           input measure_pkg::byte_t d);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[31] ^ d[i];
      r  = {r[30:0], 1'b0} ^ (fb ? measure_pkg::CRC32_POLY : 32'h0);
    end
    return r;
  endfunction

  assign crc_base = init ? measure_pkg::CRC32_INIT : crc_reg;   // Restart at first MAC byte

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst)
      crc_reg <= measure_pkg::CRC32_INIT;
    else if (init || data_en)
      crc_reg <= crc_step(crc_base, data);
  end

  // Complemented, each byte bit-reflected, MSB byte is sent first
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      crc[i] = ~crc_reg[(i / 8) * 8 + 7 - (i % 8)];
    end
  end

endmodule

`default_nettype wire

//--- hdl/measure_core.sv
`timescale 1ns/1ps
`default_nettype none

module measure_core (
  input  wire                     gmii_tx_clk,
  input  wire                     sys_rst,
  input  wire measure_pkg::byte_t gmii_rxd,
  input  wire                     gmii_rx_dv,
  input  wire                     sec_oneshot,
  input  wire [31:0]              global_counter,
  output measure_pkg::byte_t      gmii_txd,
  output logic                    gmii_tx_en,
  output logic [31:0]             rx_pps,
  output logic [31:0]             rx_throughput,
  output logic [23:0]             rx_latency,
  output logic [31:0]             rx_ipv4_ip
);

  arp_req_if req_in ();    // Parser to queue, REPLY_QUEUE_DEPTH credits
  arp_req_if req_out ();   // Queue to transmitter, one credit

  rx_frame_parser u_rx_frame_parser (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .gmii_rxd       (gmii_rxd),
    .gmii_rx_dv     (gmii_rx_dv),
    .sec_oneshot    (sec_oneshot),
    .global_counter (global_counter),
    .req            (req_in),
    .rx_pps         (rx_pps),
    .rx_throughput  (rx_throughput),
    .rx_latency     (rx_latency),
    .rx_ipv4_ip     (rx_ipv4_ip)
  );

  arp_req_queue u_arp_req_queue (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .req_in      (req_in),
    .req_out     (req_out)
  );

  arp_reply_tx u_arp_reply_tx (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .req         (req_out),
    .gmii_txd    (gmii_txd),
    .gmii_tx_en  (gmii_tx_en)
  );

endmodule

`default_nettype wire

//--- hdl/measure_pkg.sv
`default_nettype none

package measure_pkg;

  // --------------------------------------------------
  // Data and address types
  // --------------------------------------------------
  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] frame_count_t;     // Receive byte position
  typedef logic [6:0]  tx_count_t;        // Transmit byte position

  localparam mac_addr_t   LOCAL_MAC  = 48'h0037_7600_0101;
  localparam ipv4_addr_t  LOCAL_IPV4 = {8'd10, 8'd0, 8'd21, 8'd105};
  localparam logic [39:0] MAGIC_CODE = 40'hca_fe_c0_ff_ee;   // Measurement frame marker

  localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
  localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
  localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
  localparam logic [15:0] ARP_OP_REQUEST = 16'h0001;
  localparam logic [15:0] ARP_OP_REPLY   = 16'h0002;

  // --------------------------------------------------
  // Receive offsets, first destination MAC byte is 0
  // --------------------------------------------------
  localparam frame_count_t OFS_SRC_MAC   = 16'h06;
  localparam frame_count_t OFS_TYPE      = 16'h0c;
  localparam frame_count_t OFS_OPCODE    = 16'h14;
  localparam frame_count_t OFS_SENDER_IP = 16'h1c;
  localparam frame_count_t OFS_IPV4_IP   = 16'h1e;   // Overlaps the ARP sender IP
  localparam frame_count_t OFS_TARGET_IP = 16'h26;
  localparam frame_count_t OFS_MAGIC     = 16'h2a;
  localparam frame_count_t OFS_TSTAMP    = 16'h2f;
  localparam frame_count_t OFS_DECIDE    = 16'h33;

  // Reply frame layout, preamble included
  localparam tx_count_t REPLY_LEN  = 7'd72;
  localparam tx_count_t TX_OFS_DST = 7'd8;     // First byte after SFD
  localparam tx_count_t TX_OFS_PAD = 7'd50;
  localparam tx_count_t TX_OFS_FCS = 7'd68;
  localparam tx_count_t TX_GAP     = 7'd12;

  localparam logic [31:0] CRC32_POLY = 32'h04c1_1db7;
  localparam logic [31:0] CRC32_INIT = 32'hffff_ffff;

  // Reply queue
  localparam int REPLY_QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W       = $clog2(REPLY_QUEUE_DEPTH);
  localparam int CREDIT_W          = $clog2(REPLY_QUEUE_DEPTH + 1);

  typedef logic [QUEUE_PTR_W-1:0] qptr_t;
  typedef logic [CREDIT_W-1:0]    credit_t;

  localparam qptr_t   QPTR_LAST     = qptr_t'(REPLY_QUEUE_DEPTH - 1);
  localparam credit_t QUEUE_CREDITS = credit_t'(REPLY_QUEUE_DEPTH);

endpackage

`default_nettype wire

//--- hdl/rx_frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_parser (
  input  wire                     gmii_tx_clk,
  input  wire                     sys_rst,
  input  wire measure_pkg::byte_t gmii_rxd,
  input  wire                     gmii_rx_dv,
  input  wire                     sec_oneshot,
  input  wire [31:0]              global_counter,
  arp_req_if.sender               req,
  output logic [31:0]             rx_pps,
  output logic [31:0]             rx_throughput,
  output logic [23:0]             rx_latency,
  output logic [31:0]             rx_ipv4_ip
);

  measure_pkg::frame_count_t rx_count;     // Byte position in current frame
  measure_pkg::mac_addr_t    src_mac;
  measure_pkg::ipv4_addr_t   sender_ip;
  measure_pkg::ipv4_addr_t   target_ip;
  logic [15:0]               rx_type;
  logic [15:0]               rx_opcode;
  logic [39:0]               rx_magic;
  logic [31:0]               tstamp;       // Sender timestamp
  logic [31:0]               pps;
  logic [31:0]               throughput;
  measure_pkg::credit_t      credits;      // Free queue entries
  logic [31:0]               latency_full;
  logic                      magic_hit;
  logic                      arp_hit;

  function automatic logic in_field(input measure_pkg::frame_count_t pos,
                                    input measure_pkg::frame_count_t ofs,
                                    input measure_pkg::frame_count_t len);
    return (pos >= ofs) && (pos < ofs + len);
  endfunction

  assign latency_full = global_counter - tstamp;
  assign magic_hit    = (rx_magic == measure_pkg::MAGIC_CODE);
  assign arp_hit      = (rx_type == measure_pkg::ETH_TYPE_ARP) &&
                        (rx_opcode == measure_pkg::ARP_OP_REQUEST) &&
                        (target_ip == measure_pkg::LOCAL_IPV4);

  // --------------------------------------------------
  // Header fields shifted in MSB first
  // --------------------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (gmii_rx_dv) begin
      if (in_field(rx_count, measure_pkg::OFS_SRC_MAC, 16'd6))
        src_mac <= {src_mac[39:0], gmii_rxd};
      if (in_field(rx_count, measure_pkg::OFS_TYPE, 16'd2))
        rx_type <= {rx_type[7:0], gmii_rxd};
      if (in_field(rx_count, measure_pkg::OFS_OPCODE, 16'd2))
        rx_opcode <= {rx_opcode[7:0], gmii_rxd};
      if (in_field(rx_count, measure_pkg::OFS_SENDER_IP, 16'd4))
        sender_ip <= {sender_ip[23:0], gmii_rxd};
      if (in_field(rx_count, measure_pkg::OFS_TARGET_IP, 16'd4))
        target_ip <= {target_ip[23:0], gmii_rxd};
      if (in_field(rx_count, measure_pkg::OFS_MAGIC, 16'd5))
        rx_magic <= {rx_magic[31:0], gmii_rxd};
      if (in_field(rx_count, measure_pkg::OFS_TSTAMP, 16'd4))
        tstamp <= {tstamp[23:0], gmii_rxd};
    end
    if (gmii_rx_dv && rx_count == measure_pkg::OFS_DECIDE && arp_hit) begin
      req.dst_mac <= src_mac;           // Reply goes back to the requester
      req.dst_ip  <= sender_ip;
    end
  end

  // --------------------------------------------------
  // Counters, decisions and credit
  // --------------------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      rx_count      <= '0;
      pps           <= '0;
      throughput    <= '0;
      credits       <= measure_pkg::QUEUE_CREDITS;
      req.push      <= 1'b0;
      rx_pps        <= '0;
      rx_throughput <= '0;
      rx_latency    <= '0;
      rx_ipv4_ip    <= '0;
    end else begin
      req.push <= 1'b0;
      if (gmii_rx_dv) begin
        rx_count <= rx_count + 16'd1;
        if (rx_count == '0)
          pps <= pps + 32'd1;           // Count at the first byte
        if (in_field(rx_count, measure_pkg::OFS_IPV4_IP, 16'd4))
          rx_ipv4_ip <= {rx_ipv4_ip[23:0], gmii_rxd};
        if (rx_count == measure_pkg::OFS_DECIDE) begin
          if (magic_hit)
            rx_latency <= latency_full[23:0];
          else if (arp_hit && credits != '0)
            req.push <= 1'b1;           // Dropped without credit
        end
      end else if (rx_count != '0) begin
        throughput <= throughput + {16'h0, rx_count};   // Frame end
        rx_count   <= '0;
      end

      case ({req.credit, req.push})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase

      if (sec_oneshot) begin
        rx_pps        <= pps;
        rx_throughput <= throughput;
        pps           <= '0;
        throughput    <= '0;
      end
    end
  end

  // The queue returns at most the credits the parser has spent
  credit_within_capacity: assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    req.credit |-> credits != measure_pkg::QUEUE_CREDITS);

endmodule

`default_nettype wire

//--- measure_core.f
hdl/measure_pkg.sv
hdl/arp_req_if.sv
hdl/eth_crc32.sv
hdl/rx_frame_parser.sv
hdl/arp_req_queue.sv
hdl/arp_reply_tx.sv
hdl/measure_core.sv
verif/tb_measure_core.sv

//--- verif/measure_golden.txt
# Columns: command then hex values, one command per line
# frame LEN BYTES | gcount VALUE | oneshot PPS THROUGHPUT | latency VALUE | ipv4 ADDR
# reply BYTES (68, preamble to padding, FCS is appended by the testbench) | noreply
gcount 00000010
frame 3c 00 37 76 00 01 01 02 00 00 00 00 aa 08 00 45 00 00 2e 00 00 00 00 40 11 00 00 0a 00 15 01 0a 00 15 69 30 39 30 39 00 1a 00 00 ca fe c0 ff ee 01 00 00 20 00 00 00 00 00 00 00 00 00
latency fffff0
ipv4 0a001569
gcount 00200000
frame 3c 00 37 76 00 01 01 02 00 00 00 00 aa 08 00 45 00 00 2e 00 00 00 00 40 11 00 00 0a 00 15 01 0a 00 15 6a 30 39 30 39 00 1a 00 00 ca fe c0 ff ef 00 00 00 01 00 00 00 00 00 00 00 00 00
latency fffff0
ipv4 0a00156a
oneshot 00000002 00000078
oneshot 00000000 00000000
reply 55 55 55 55 55 55 55 d5 02 00 00 00 00 aa 00 37 76 00 01 01 08 06 00 01 08 00 06 04 00 02 00 37 76 00 01 01 0a 00 15 69 02 00 00 00 00 aa 0a 00 15 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
frame 3c ff ff ff ff ff ff 02 00 00 00 00 aa 08 06 00 01 08 00 06 04 00 01 02 00 00 00 00 aa 0a 00 15 01 00 00 00 00 00 00 0a 00 15 69 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
ipv4 15010000
frame 3c ff ff ff ff ff ff 02 00 00 00 00 aa 08 06 00 01 08 00 06 04 00 01 02 00 00 00 00 aa 0a 00 15 01 00 00 00 00 00 00 0a 00 15 6a 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
frame 3c 00 37 76 00 01 01 02 00 00 00 00 aa 08 06 00 01 08 00 06 04 00 02 02 00 00 00 00 aa 0a 00 15 01 00 37 76 00 01 01 0a 00 15 69 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
noreply
reply 55 55 55 55 55 55 55 d5 02 00 00 00 00 bb 00 37 76 00 01 01 08 06 00 01 08 00 06 04 00 02 00 37 76 00 01 01 0a 00 15 69 02 00 00 00 00 bb 0a 00 15 02 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
reply 55 55 55 55 55 55 55 d5 02 00 00 00 00 cc 00 37 76 00 01 01 08 06 00 01 08 00 06 04 00 02 00 37 76 00 01 01 0a 00 15 69 02 00 00 00 00 cc 0a 00 15 03 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
frame 3c ff ff ff ff ff ff 02 00 00 00 00 bb 08 06 00 01 08 00 06 04 00 01 02 00 00 00 00 bb 0a 00 15 02 00 00 00 00 00 00 0a 00 15 69 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
frame 3c ff ff ff ff ff ff 02 00 00 00 00 cc 08 06 00 01 08 00 06 04 00 01 02 00 00 00 00 cc 0a 00 15 03 00 00 00 00 00 00 0a 00 15 69 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
ipv4 15030000
oneshot 00000005 0000012c

//--- verif/tb_measure_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_measure_core;

  localparam int REPLY_BYTES     = 72;    // Preamble, frame and FCS
  localparam int MIN_TX_GAP      = 12;
  localparam int CYCLES_PER_LINE = 200;
  localparam int NOREPLY_WAIT    = 150;

  logic        gmii_tx_clk = 1'b0;
  logic        sys_rst;
  logic [7:0]  gmii_rxd;
  logic        gmii_rx_dv;
  logic        sec_oneshot;
  logic [31:0] global_counter;
  logic [7:0]  gmii_txd;
  logic        gmii_tx_en;
  logic [31:0] rx_pps;
  logic [31:0] rx_throughput;
  logic [23:0] rx_latency;
  logic [31:0] rx_ipv4_ip;

  int          fd;
  logic [7:0]  lfsr;
  logic [7:0]  exp_q[$];                  // Expected reply bytes in wire order
  logic [7:0]  exp_byte;
  logic        in_burst    = 1'b0;
  int          burst_len   = 0;
  int          bursts      = 0;
  int          idle_cycles = 0;
  int          cycles      = 0;
  int          cycle_limit = 1000000;     // Replaced once the golden file is sized

  measure_core u_measure_core (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .gmii_rxd       (gmii_rxd),
    .gmii_rx_dv     (gmii_rx_dv),
    .sec_oneshot    (sec_oneshot),
    .global_counter (global_counter),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en),
    .rx_pps         (rx_pps),
    .rx_throughput  (rx_throughput),
    .rx_latency     (rx_latency),
    .rx_ipv4_ip     (rx_ipv4_ip)
  );

  always #50 gmii_tx_clk = ~gmii_tx_clk;   // 100 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // 8-bit Fibonacci LFSR with taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic draw_gap(output int gap);
    gap = 0;
    for (int i = 0; i < 3; i++) begin
      lfsr = lfsr_next(lfsr);
      gap  = gap * 2 + int'(lfsr[0]);
    end
    gap = gap + 3;                        // 3 to 10 idle cycles
  endtask

  // Reflected Ethernet CRC-32 taking the LSB of each byte first
  function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++)
      r = r[0] ? ((r >> 1) ^ 32'hedb8_8320) : (r >> 1);
    return r;
  endfunction

  // --------------------------------------------------
  // Golden file commands
  // --------------------------------------------------
  task automatic send_frame;
    int         len;
    int         gap;
    int         code;
    logic [7:0] b;
    code = $fscanf(fd, "%h", len);
    assert (code == 1) else abort_run("golden frame line has no length");
    for (int i = 0; i < len; i++) begin
      code = $fscanf(fd, "%h", b);
      assert (code == 1) else abort_run("golden frame line ends early");
      @(posedge gmii_tx_clk);
      #1;
      gmii_rxd   = b;
      gmii_rx_dv = 1'b1;
    end
    @(posedge gmii_tx_clk);
    #1;
    gmii_rx_dv = 1'b0;
    gmii_rxd   = 8'h00;
    draw_gap(gap);
    repeat (gap - 1) @(posedge gmii_tx_clk);   // The cycle with dv low is the first
  endtask

  task automatic expect_reply;
    logic [31:0] crc;
    logic [7:0]  b;
    int          code;
    crc = 32'hffff_ffff;
    for (int i = 0; i < REPLY_BYTES - 4; i++) begin
      code = $fscanf(fd, "%h", b);
      assert (code == 1) else abort_run("golden reply line ends early");
      exp_q.push_back(b);
      if (i >= 8)
        crc = crc_update(crc, b);         // FCS starts after the SFD
    end
    crc = ~crc;
    exp_q.push_back(crc[7:0]);            // FCS goes out low byte first
    exp_q.push_back(crc[15:8]);
    exp_q.push_back(crc[23:16]);
    exp_q.push_back(crc[31:24]);
  endtask

  task automatic pulse_oneshot(input logic [31:0] pps, input logic [31:0] thr);
    @(posedge gmii_tx_clk);
    #1 sec_oneshot = 1'b1;
    @(posedge gmii_tx_clk);
    #1 sec_oneshot = 1'b0;
    assert (rx_pps == pps) else abort_run($sformatf(
      "error at %0d ns: rx_pps is %0d, expected %0d", $time, rx_pps, pps));
    assert (rx_throughput == thr) else abort_run($sformatf(
      "error at %0d ns: rx_throughput is %0d, expected %0d", $time, rx_throughput, thr));
  endtask

  task automatic wait_replies_done;
    while (exp_q.size() != 0 || in_burst)
      @(posedge gmii_tx_clk);
  endtask

  // --------------------------------------------------
  // Transmit monitor
  // --------------------------------------------------
  always @(negedge gmii_tx_clk) begin
    if (!sys_rst && gmii_tx_en) begin
      if (!in_burst) begin
        assert (exp_q.size() >= REPLY_BYTES) else abort_run($sformatf(
          "error at %0d ns: transmission started with no reply expected", $time));
        if (bursts > 0) begin
          assert (idle_cycles >= MIN_TX_GAP) else abort_run($sformatf(
            "error at %0d ns: only %0d idle cycles between replies", $time, idle_cycles));
        end
        in_burst  = 1'b1;
        burst_len = 0;
      end
      assert (burst_len < REPLY_BYTES) else abort_run($sformatf(
        "error at %0d ns: reply longer than %0d bytes", $time, REPLY_BYTES));
      exp_byte = exp_q.pop_front();
      assert (gmii_txd === exp_byte) else abort_run($sformatf(
        "error at %0d ns: reply byte %0d is %h, expected %h",
        $time, burst_len, gmii_txd, exp_byte));
      burst_len++;
    end else if (!sys_rst) begin
      if (in_burst) begin
        assert (burst_len == REPLY_BYTES) else abort_run($sformatf(
          "error at %0d ns: reply has %0d bytes, expected %0d", $time, burst_len, REPLY_BYTES));
        in_burst    = 1'b0;
        bursts++;
        idle_cycles = 0;
      end
      idle_cycles++;
    end
  end

  always @(posedge gmii_tx_clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
      abort_run($sformatf("simulation timed out after %0d clock cycles", cycles));
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    logic [8*16-1:0]  cmd;
    logic [8*512-1:0] line;
    logic [31:0]      val;
    logic [31:0]      val2;
    int               code;
    int               lines;
    sys_rst        = 1'b1;
    gmii_rxd       = 8'h00;
    gmii_rx_dv     = 1'b0;
    sec_oneshot    = 1'b0;
    global_counter = 32'h0;
    lfsr           = 8'd47;
    lines          = 0;
    fd = $fopen("verif/measure_golden.txt", "r");
    assert (fd != 0) else abort_run("cannot open verif/measure_golden.txt");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0)
        lines++;
    end
    $fclose(fd);
    cycle_limit = CYCLES_PER_LINE * lines;
    fd = $fopen("verif/measure_golden.txt", "r");
    repeat (5) @(posedge gmii_tx_clk);
    #1 sys_rst = 1'b0;

    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        code = $fgets(line, fd);          // Skip comment text
      end else if (cmd == "frame") begin
        send_frame();
      end else if (cmd == "gcount") begin
        code = $fscanf(fd, "%h", val);
        @(posedge gmii_tx_clk);
        #1 global_counter = val;
      end else if (cmd == "oneshot") begin
        code = $fscanf(fd, "%h %h", val, val2);
        pulse_oneshot(val, val2);
      end else if (cmd == "latency") begin
        code = $fscanf(fd, "%h", val);
        @(posedge gmii_tx_clk);
        #1;
        assert (rx_latency == val[23:0]) else abort_run($sformatf(
          "error at %0d ns: rx_latency is %h, expected %h", $time, rx_latency, val[23:0]));
      end else if (cmd == "ipv4") begin
        code = $fscanf(fd, "%h", val);
        @(posedge gmii_tx_clk);
        #1;
        assert (rx_ipv4_ip == val) else abort_run($sformatf(
          "error at %0d ns: rx_ipv4_ip is %h, expected %h", $time, rx_ipv4_ip, val));
      end else if (cmd == "reply") begin
        expect_reply();
      end else if (cmd == "noreply") begin
        wait_replies_done();
        repeat (NOREPLY_WAIT) @(posedge gmii_tx_clk);   // Monitor flags any burst here
      end else begin
        abort_run("unknown command in verif/measure_golden.txt");
      end
    end
    $fclose(fd);

    wait_replies_done();
    repeat (NOREPLY_WAIT) @(posedge gmii_tx_clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
